// ==== filelist.f ====
verilog/chirp_pkg.sv
verilog/sin_cos_table.sv
verilog/chirp_phase_seq.sv
verilog/phase_fifo.sv
verilog/iq_synth.sv
verilog/chirp_sig_top.sv
testbench/chirp_sig_assert.sv
testbench/chirp_sig_tb.sv

// ==== testbench/chirp_sig_assert.sv ====
`default_nettype none

module chirp_sig_assert (
  input wire                            clk,
  input wire                            rst,
  input wire                            out_valid,
  input wire                            out_ready,
  input wire [chirp_pkg::SAMPLE_W-1:0]  out_i,
  input wire [chirp_pkg::SAMPLE_W-1:0]  out_q,
  input wire                            out_last,
  input wire                            out_sync
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0; // read by the testbench at the end of the run

  // a stalled sample must stay put until it is taken
  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_i) && $stable(out_q) &&
                                $stable(out_last) && $stable(out_sync))
    else begin
      $error("out_valid dropped or output data changed while stalled");
      fail_cnt++;
    end

  flags_need_valid: assert property (@(posedge clk) disable iff (rst)
    !out_valid |-> !out_last && !out_sync)
    else begin
      $error("out_last or out_sync high without out_valid");
      fail_cnt++;
    end

  sync_needs_last: assert property (@(posedge clk) disable iff (rst)
    out_sync |-> out_last)
    else begin
      $error("out_sync high without out_last");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== testbench/chirp_sig_tb.sv ====
`default_nettype none

module chirp_sig_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import chirp_pkg::*;

  localparam count_t SPS       = 16'd8;  // samples per symbol
  localparam count_t SPF       = 16'd4;  // symbols per frame
  localparam count_t DWELL     = 16'd5;  // pilot samples per hop
  localparam count_t HOPS      = 16'd3;
  localparam count_t FPS       = 16'd2;  // frames per sync group
  localparam phase_t START_PH  = 24'h000000; // both tones peak together at frame start
  localparam phase_t START_INC = 24'h0a3000;
  localparam phase_t INC_STEP  = 24'h051000;
  localparam phase_t PH_SHIFT  = 24'h013400;
  localparam phase_t P_INC     = 24'h1c8000;
  localparam phase_t P_STEP    = 24'h0e4000;

  localparam int FRAME_LEN   = int'(SPS) * int'(SPF);
  localparam int EXP_W       = 2 * SAMPLE_W + 2;
  localparam int QUIET_CYC   = 8;
  localparam int T1_CYC      = 20;
  localparam int T2_CYC      = 2 * FRAME_LEN * int'(FPS); // two sync groups
  localparam int T4_CYC      = 400;
  localparam int T5_CYC      = 3 * FRAME_LEN + 40;
  localparam int TEST_CYC    = T1_CYC + T2_CYC + T4_CYC + T5_CYC + 4 * QUIET_CYC;
  localparam int TIMEOUT_CYC = 2 * TEST_CYC + 10 + 200;

  logic    clk;
  logic    rst;
  logic    run;
  logic    restart;
  logic    out_valid;
  logic    out_ready;
  sample_t out_i;
  sample_t out_q;
  logic    out_last;
  logic    out_sync;

  logic [EXP_W-1:0] exp_word;
  logic [31:0]      lcg_state = 32'hd6855da1;
  int               exp_idx   = 0; // next expected index since reset or restart
  int               n_out     = 0;
  int               n_last    = 0;
  int               n_sync    = 0;
  int               errors    = 0;
  int               cycle_cnt = 0;

  chirp_sig_top #(
    .SAMPLES_PER_SYMB      (SPS),
    .SYMBS_PER_FRAME       (SPF),
    .START_PH              (START_PH),
    .START_INC             (START_INC),
    .INC_STEP              (INC_STEP),
    .PH_SHIFT              (PH_SHIFT),
    .PILOT_SAMPLES_PER_HOP (DWELL),
    .PILOT_HOPS            (HOPS),
    .PILOT_START_INC       (P_INC),
    .PILOT_INC_STEP        (P_STEP),
    .FRAMES_PER_SYNC       (FPS)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .restart   (restart),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_i     (out_i),
    .out_q     (out_q),
    .out_last  (out_last),
    .out_sync  (out_sync)
  );

  bind chirp_sig_top chirp_sig_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_i     (out_i),
    .out_q     (out_q),
    .out_last  (out_last),
    .out_sync  (out_sync)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // sine of table address a, rounded half away from zero
  function automatic int table_sine(input int a);
    real x;
    x = $sin(6.283185307179586 * (a % TABLE_SIZE) / TABLE_SIZE) * TABLE_AMP;
    if (x >= 0.0) begin
      return $rtoi(x + 0.5);
    end
    return -$rtoi(0.5 - x);
  endfunction

  function automatic int clip_sample(input int v);
    if (v > TABLE_AMP) begin
      return TABLE_AMP;
    end
    if (v < -TABLE_AMP - 1) begin
      return -TABLE_AMP - 1;
    end
    return v;
  endfunction

  // expected {i, q, last, sync} of sample n after reset or restart
  function automatic logic [EXP_W-1:0] expected_sample(input int n);
    int     pos;
    int     symb;
    int     samp;
    int     ppos;
    int     ca;
    int     pa;
    int     iv;
    int     qv;
    logic   last;
    logic   sync;
    phase_t chirp_ph;
    phase_t pilot_ph;
    pos  = n % FRAME_LEN;
    symb = pos / int'(SPS);
    samp = pos % int'(SPS);
    chirp_ph = START_PH - phase_t'(symb) * PH_SHIFT +
               phase_t'(samp) * (START_INC + phase_t'(symb) * INC_STEP);
    ppos = n % (int'(DWELL) * int'(HOPS));
    pilot_ph = START_PH + phase_t'(ppos % int'(DWELL)) *
               (P_INC + phase_t'(ppos / int'(DWELL)) * P_STEP);
    ca = int'(chirp_ph[PHASE_W-1 -: TABLE_ADDR_W]);
    pa = int'(pilot_ph[PHASE_W-1 -: TABLE_ADDR_W]);
    iv = clip_sample(table_sine(ca + TABLE_QUARTER) + table_sine(pa + TABLE_QUARTER));
    qv = clip_sample(table_sine(ca) + table_sine(pa));
    last = (pos == FRAME_LEN - 1);
    sync = last && ((n / FRAME_LEN) % int'(FPS) == int'(FPS) - 1);
    return {sample_t'(iv), sample_t'(qv), last, sync};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // output idle for a while with out_ready high means the pipe is empty
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYC) begin
      @(negedge clk);
      if (out_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    next_cycle();
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // sampled mid-cycle, the value seen is the one taken at the next rising edge
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      exp_word = expected_sample(exp_idx);
      assert (out_i === exp_word[EXP_W-1 -: SAMPLE_W]) else begin
        $display("FAILED out_i: got %h expected %h at sample %0d",
                 out_i, exp_word[EXP_W-1 -: SAMPLE_W], exp_idx);
        errors++;
      end
      assert (out_q === exp_word[SAMPLE_W+1 -: SAMPLE_W]) else begin
        $display("FAILED out_q: got %h expected %h at sample %0d",
                 out_q, exp_word[SAMPLE_W+1 -: SAMPLE_W], exp_idx);
        errors++;
      end
      assert (out_last === exp_word[1]) else begin
        $display("FAILED out_last: got %h expected %h at sample %0d",
                 out_last, exp_word[1], exp_idx);
        errors++;
      end
      assert (out_sync === exp_word[0]) else begin
        $display("FAILED out_sync: got %h expected %h at sample %0d",
                 out_sync, exp_word[0], exp_idx);
        errors++;
      end
      n_last += int'(out_last);
      n_sync += int'(out_sync);
      exp_idx++;
      n_out++;
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the output stream stopped", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int err0;
    int cnt0;
    int last0;
    int sync0;
    int lead;
    rst       = 1'b1;
    run       = 1'b0;
    restart   = 1'b0;
    out_ready = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    // test 1: idle output while run is low
    err0 = errors;
    for (int k = 0; k < T1_CYC; k++) begin
      out_ready = k[0];
      @(negedge clk);
      assert (!out_valid && !out_last && !out_sync) else begin
        $display("output became valid or flagged while run was low");
        errors++;
      end
      next_cycle();
    end
    report_test("test 1 idle after reset", err0);

    // tests 2 and 3: two sync groups at full rate
    err0  = errors;
    cnt0  = n_out;
    last0 = n_last;
    sync0 = n_sync;
    out_ready = 1'b1;
    run = 1'b1;
    repeat (T2_CYC) next_cycle();
    run = 1'b0;
    wait_idle();
    assert (n_out - cnt0 == T2_CYC) else begin
      $display("FAILED sample count: got %h expected %h", n_out - cnt0, T2_CYC);
      errors++;
    end
    report_test("test 2 full rate samples", err0);
    err0 = errors;
    assert (n_last - last0 == 4 && n_sync - sync0 == 2) else begin
      $display("FAILED last/sync count: got %h/%h expected 4/2",
               n_last - last0, n_sync - sync0);
      errors++;
    end
    report_test("test 3 frame and sync flags", err0);

    // test 4: random back-pressure with run toggling
    err0 = errors;
    cnt0 = n_out;
    for (int k = 0; k < T4_CYC; k++) begin
      lcg_state = lcg_next(lcg_state);
      out_ready = lcg_state[31];
      run       = lcg_state[30] | lcg_state[29]; // high about 3 of 4 cycles
      next_cycle();
    end
    run = 1'b0;
    out_ready = 1'b1;
    wait_idle();
    assert (n_out > cnt0) else begin
      $display("no samples came out under random back-pressure");
      errors++;
    end
    report_test("test 4 random back-pressure", err0);

    // test 5: restart 13 samples into a frame, with samples queued
    err0 = errors;
    cnt0 = n_out;
    lead = FRAME_LEN - (exp_idx % FRAME_LEN) + 13;
    run = 1'b1;
    repeat (lead) next_cycle();
    out_ready = 1'b0;
    restart = 1'b1; // same edge as a transfer
    next_cycle();
    restart = 1'b0;
    run = 1'b0;
    repeat (4) next_cycle();
    out_ready = 1'b1;
    wait_idle();
    assert (n_out - cnt0 == lead + 1) else begin
      $display("FAILED drained count: got %h expected %h", n_out - cnt0, lead + 1);
      errors++;
    end
    exp_idx = 0;
    cnt0 = n_out;
    run = 1'b1;
    repeat (FRAME_LEN + 8) next_cycle();
    run = 1'b0;
    wait_idle();
    assert (n_out - cnt0 == FRAME_LEN + 8) else begin
      $display("FAILED count after restart: got %h expected %h",
               n_out - cnt0, FRAME_LEN + 8);
      errors++;
    end
    report_test("test 5 restart mid-frame", err0);

    errors += u_dut.u_assert.fail_cnt;
    $display("%0d samples checked, %0d lasts, %0d syncs, %0d errors",
             n_out, n_last, n_sync, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/chirp_phase_seq.sv ====
`default_nettype none

module chirp_phase_seq #(
  parameter chirp_pkg::count_t SAMPLES_PER_SYMB      = 16'd32,
  parameter chirp_pkg::count_t SYMBS_PER_FRAME       = 16'd16,
  parameter chirp_pkg::phase_t START_PH              = 24'h000000,
  parameter chirp_pkg::phase_t START_INC             = 24'h010000,
  parameter chirp_pkg::phase_t INC_STEP              = 24'h004000,
  parameter chirp_pkg::phase_t PH_SHIFT              = 24'h000800,
  parameter chirp_pkg::count_t PILOT_SAMPLES_PER_HOP = 16'd64,
  parameter chirp_pkg::count_t PILOT_HOPS            = 16'd8,
  parameter chirp_pkg::phase_t PILOT_START_INC       = 24'h020000,
  parameter chirp_pkg::phase_t PILOT_INC_STEP        = 24'h008000,
  parameter chirp_pkg::count_t FRAMES_PER_SYNC       = 16'd4
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      restart,
  input  wire                      run,
  output logic                     gen_valid,
  input  wire                      gen_ready,
  output chirp_pkg::phase_t        gen_chirp_ph,
  output chirp_pkg::phase_t        gen_pilot_ph,
  output logic                     gen_last,
  output logic                     gen_sync
);

  import chirp_pkg::*;

  localparam count_t SAMP_LAST  = count_t'(SAMPLES_PER_SYMB - 1);
  localparam count_t SYMB_LAST  = count_t'(SYMBS_PER_FRAME - 1);
  localparam count_t DWELL_LAST = count_t'(PILOT_SAMPLES_PER_HOP - 1);
  localparam count_t HOP_LAST   = count_t'(PILOT_HOPS - 1);
  localparam count_t SYNC_LAST  = count_t'(FRAMES_PER_SYNC - 1);

  count_t samp_cnt;
  count_t symb_cnt;
  count_t frame_cnt;
  count_t pilot_cnt;
  count_t hop_cnt;
  phase_t chirp_ph;
  phase_t chirp_inc;
  phase_t symb_ph;   // start phase of the current symbol
  phase_t pilot_ph;
  phase_t pilot_inc;
  logic   xfer;
  logic   symb_end;
  logic   frame_end;
  logic   hop_end;

  assign xfer      = gen_valid && gen_ready;
  assign symb_end  = (samp_cnt == SAMP_LAST);
  assign frame_end = symb_end && (symb_cnt == SYMB_LAST);
  assign hop_end   = (pilot_cnt == DWELL_LAST);

  assign gen_valid    = run;
  assign gen_chirp_ph = chirp_ph;
  assign gen_pilot_ph = pilot_ph;
  assign gen_last     = frame_end;
  assign gen_sync     = frame_end && (frame_cnt == SYNC_LAST); // last frame of the group

  // chirp: phase ramp per symbol, increment steps per symbol
  always_ff @(posedge clk) begin
    if (rst || restart) begin
      samp_cnt  <= '0;
      symb_cnt  <= '0;
      frame_cnt <= '0;
      chirp_ph  <= START_PH;
      chirp_inc <= START_INC;
      symb_ph   <= START_PH;
    end else if (xfer) begin
      if (!symb_end) begin
        samp_cnt <= samp_cnt + 1'b1;
        chirp_ph <= chirp_ph + chirp_inc;
      end else if (!frame_end) begin
        samp_cnt  <= '0;
        symb_cnt  <= symb_cnt + 1'b1;
        chirp_ph  <= symb_ph - PH_SHIFT; // next symbol starts further back
        symb_ph   <= symb_ph - PH_SHIFT;
        chirp_inc <= chirp_inc + INC_STEP;
      end else begin
        samp_cnt  <= '0;
        symb_cnt  <= '0;
        chirp_ph  <= START_PH;
        chirp_inc <= START_INC;
        symb_ph   <= START_PH;
        if (frame_cnt == SYNC_LAST) begin
          frame_cnt <= '0;
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end
    end
  end

  // pilot hops run free of the frame structure
  always_ff @(posedge clk) begin
    if (rst || restart) begin
      pilot_cnt <= '0;
      hop_cnt   <= '0;
      pilot_ph  <= START_PH;
      pilot_inc <= PILOT_START_INC;
    end else if (xfer) begin
      if (!hop_end) begin
        pilot_cnt <= pilot_cnt + 1'b1;
        pilot_ph  <= pilot_ph + pilot_inc;
      end else begin
        pilot_cnt <= '0;
        pilot_ph  <= START_PH;
        if (hop_cnt == HOP_LAST) begin
          hop_cnt   <= '0;
          pilot_inc <= PILOT_START_INC; // wrap to first hop
        end else begin
          hop_cnt   <= hop_cnt + 1'b1;
          pilot_inc <= pilot_inc + PILOT_INC_STEP;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/chirp_pkg.sv ====
`default_nettype none

package chirp_pkg;

  localparam int PHASE_W      = 24; // one turn = 2**PHASE_W
  localparam int SAMPLE_W     = 16;
  localparam int COUNT_W      = 16;
  localparam int TABLE_ADDR_W = 10; // top bits of a phase

  localparam int TABLE_SIZE    = 2 ** TABLE_ADDR_W;
  localparam int TABLE_QUARTER = TABLE_SIZE / 4; // cosine offset
  localparam int TABLE_AMP     = 2 ** (SAMPLE_W - 1) - 1; // largest positive sample

  localparam real TWO_PI = 6.283185307179586;

  typedef logic [PHASE_W-1:0]      phase_t;
  typedef logic [SAMPLE_W-1:0]     sample_t; // two's complement
  typedef logic [COUNT_W-1:0]      count_t;
  typedef logic [TABLE_ADDR_W-1:0] table_addr_t;

  // sine table entry k, rounded to nearest with halves away from zero
  function automatic sample_t sine_entry(input int k);
    real x;
    int  r;
    x = $sin(TWO_PI * k / TABLE_SIZE) * TABLE_AMP;
    if (x >= 0.0) begin
      r = $rtoi(x + 0.5);
    end else begin
      r = -$rtoi(0.5 - x);
    end
    return sample_t'(r);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/chirp_sig_top.sv ====
`default_nettype none

module chirp_sig_top #(
  parameter chirp_pkg::count_t SAMPLES_PER_SYMB      = 16'd32,
  parameter chirp_pkg::count_t SYMBS_PER_FRAME       = 16'd16,
  parameter chirp_pkg::phase_t START_PH              = 24'h000000,
  parameter chirp_pkg::phase_t START_INC             = 24'h010000,
  parameter chirp_pkg::phase_t INC_STEP              = 24'h004000,
  parameter chirp_pkg::phase_t PH_SHIFT              = 24'h000800,
  parameter chirp_pkg::count_t PILOT_SAMPLES_PER_HOP = 16'd64,
  parameter chirp_pkg::count_t PILOT_HOPS            = 16'd8,
  parameter chirp_pkg::phase_t PILOT_START_INC       = 24'h020000,
  parameter chirp_pkg::phase_t PILOT_INC_STEP        = 24'h008000,
  parameter chirp_pkg::count_t FRAMES_PER_SYNC       = 16'd4,
  parameter int                FIFO_DEPTH            = 4
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      run,
  input  wire                      restart,
  output logic                     out_valid,
  input  wire                      out_ready,
  output chirp_pkg::sample_t       out_i,
  output chirp_pkg::sample_t       out_q,
  output logic                     out_last,
  output logic                     out_sync
);

  import chirp_pkg::*;

  logic   gen_valid;
  logic   gen_ready;
  phase_t gen_chirp_ph;
  phase_t gen_pilot_ph;
  logic   gen_last;
  logic   gen_sync;
  logic   buf_valid;
  logic   buf_ready;
  phase_t buf_chirp_ph;
  phase_t buf_pilot_ph;
  logic   buf_last;
  logic   buf_sync;

  chirp_phase_seq #(
    .SAMPLES_PER_SYMB      (SAMPLES_PER_SYMB),
    .SYMBS_PER_FRAME       (SYMBS_PER_FRAME),
    .START_PH              (START_PH),
    .START_INC             (START_INC),
    .INC_STEP              (INC_STEP),
    .PH_SHIFT              (PH_SHIFT),
    .PILOT_SAMPLES_PER_HOP (PILOT_SAMPLES_PER_HOP),
    .PILOT_HOPS            (PILOT_HOPS),
    .PILOT_START_INC       (PILOT_START_INC),
    .PILOT_INC_STEP        (PILOT_INC_STEP),
    .FRAMES_PER_SYNC       (FRAMES_PER_SYNC)
  ) u_seq (
    .clk          (clk),
    .rst          (rst),
    .restart      (restart),
    .run          (run),
    .gen_valid    (gen_valid),
    .gen_ready    (gen_ready),
    .gen_chirp_ph (gen_chirp_ph),
    .gen_pilot_ph (gen_pilot_ph),
    .gen_last     (gen_last),
    .gen_sync     (gen_sync)
  );

  // restart does not flush queued phases
  phase_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (gen_valid),
    .in_ready     (gen_ready),
    .in_chirp_ph  (gen_chirp_ph),
    .in_pilot_ph  (gen_pilot_ph),
    .in_last      (gen_last),
    .in_sync      (gen_sync),
    .out_valid    (buf_valid),
    .out_ready    (buf_ready),
    .out_chirp_ph (buf_chirp_ph),
    .out_pilot_ph (buf_pilot_ph),
    .out_last     (buf_last),
    .out_sync     (buf_sync)
  );

  iq_synth u_synth (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (buf_valid),
    .in_ready    (buf_ready),
    .in_chirp_ph (buf_chirp_ph),
    .in_pilot_ph (buf_pilot_ph),
    .in_last     (buf_last),
    .in_sync     (buf_sync),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_i       (out_i),
    .out_q       (out_q),
    .out_last    (out_last),
    .out_sync    (out_sync)
  );

endmodule

`default_nettype wire

// ==== verilog/iq_synth.sv ====
`default_nettype none

module iq_synth (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      in_valid,
  output logic                     in_ready,
  input  chirp_pkg::phase_t        in_chirp_ph,
  input  chirp_pkg::phase_t        in_pilot_ph,
  input  wire                      in_last,
  input  wire                      in_sync,
  output logic                     out_valid,
  input  wire                      out_ready,
  output chirp_pkg::sample_t       out_i,
  output chirp_pkg::sample_t       out_q,
  output logic                     out_last,
  output logic                     out_sync
);

  import chirp_pkg::*;

  logic    advance;
  logic    s1_valid;
  logic    s1_last;
  logic    s1_sync;
  sample_t chirp_sin;
  sample_t chirp_cos;
  sample_t pilot_sin;
  sample_t pilot_cos;

  // add two samples, saturate to the sample range
  function automatic sample_t add_clip(input sample_t a, input sample_t b);
    logic [SAMPLE_W:0] sum;
    sum = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
    if (sum[SAMPLE_W] != sum[SAMPLE_W-1]) begin
      return sum[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}} : {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
    return sum[SAMPLE_W-1:0];
  endfunction

  assign advance  = !out_valid || out_ready; // whole pipe moves together
  assign in_ready = advance;

  sin_cos_table u_chirp_tab (
    .clk     (clk),
    .en      (advance),
    .addr    (in_chirp_ph[PHASE_W-1 -: TABLE_ADDR_W]),
    .sin_val (chirp_sin),
    .cos_val (chirp_cos)
  );

  sin_cos_table u_pilot_tab (
    .clk     (clk),
    .en      (advance),
    .addr    (in_pilot_ph[PHASE_W-1 -: TABLE_ADDR_W]),
    .sin_val (pilot_sin),
    .cos_val (pilot_cos)
  );

  // stage 1 control, beside the table registers
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s1_sync  <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid;
      s1_last  <= in_valid && in_last; // flags only with valid data
      s1_sync  <= in_valid && in_sync;
    end
  end

  // stage 2 sum and clip
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_sync  <= 1'b0;
    end else if (advance) begin
      out_valid <= s1_valid;
      out_last  <= s1_last;
      out_sync  <= s1_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_i <= add_clip(chirp_cos, pilot_cos);
      out_q <= add_clip(chirp_sin, pilot_sin);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/phase_fifo.sv ====
`default_nettype none

module phase_fifo #(
  parameter int FIFO_DEPTH = 4 // power of two
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      in_valid,
  output logic                     in_ready,
  input  chirp_pkg::phase_t        in_chirp_ph,
  input  chirp_pkg::phase_t        in_pilot_ph,
  input  wire                      in_last,
  input  wire                      in_sync,
  output logic                     out_valid,
  input  wire                      out_ready,
  output chirp_pkg::phase_t        out_chirp_ph,
  output chirp_pkg::phase_t        out_pilot_ph,
  output logic                     out_last,
  output logic                     out_sync
);

  import chirp_pkg::*;

  localparam int ADDR_W  = $clog2(FIFO_DEPTH);
  localparam int ENTRY_W = 2 * PHASE_W + 2;

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [ADDR_W:0]    wr_ptr; // extra bit tells full from empty
  logic [ADDR_W:0]    rd_ptr;
  logic [ENTRY_W-1:0] rd_entry;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);
  assign push  = in_valid && !full;
  assign pop   = out_valid && out_ready;

  assign in_ready  = !full;
  assign out_valid = !empty;

  // show-ahead read of the head entry
  assign rd_entry     = mem[rd_ptr[ADDR_W-1:0]];
  assign out_chirp_ph = rd_entry[ENTRY_W-1 -: PHASE_W];
  assign out_pilot_ph = rd_entry[PHASE_W+1 -: PHASE_W];
  assign out_last     = rd_entry[1];
  assign out_sync     = rd_entry[0];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= {in_chirp_ph, in_pilot_ph, in_last, in_sync};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sin_cos_table.sv ====
`default_nettype none

module sin_cos_table (
  input  wire                      clk,
  input  wire                      en,
  input  chirp_pkg::table_addr_t   addr,
  output chirp_pkg::sample_t       sin_val,
  output chirp_pkg::sample_t       cos_val
);

  import chirp_pkg::*;

  localparam table_addr_t QUARTER = table_addr_t'(TABLE_QUARTER);

  sample_t     sine_rom [TABLE_SIZE];
  table_addr_t cos_addr;

  // full-wave table, one sine period over the address range
  initial begin
    for (int k = 0; k < TABLE_SIZE; k++) begin
      sine_rom[k] = sine_entry(k);
    end
  end

  assign cos_addr = addr + QUARTER; // wraps at a full turn

  always_ff @(posedge clk) begin
    if (en) begin
      sin_val <= sine_rom[addr];
      cos_val <= sine_rom[cos_addr];
    end
  end

endmodule

`default_nettype wire
